// File: src/riscv_pkg.sv
package riscv_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int xlen = 32;                    // data and address width

    typedef logic [xlen-1:0]         word_t;     // register data, pc, immediates
    typedef logic [4:0]              reg_addr_t; // x0..x31
    typedef logic [6:0]              opcode_t;   // major opcode, inst[6:0]
    typedef logic [$clog2(xlen)-1:0] shamt_t;    // shift amount, low bits of operand b

    // ----------------------------------------
    // major opcodes (rv32i base)
    // ----------------------------------------
    localparam opcode_t op_lui      = 7'b0110111;
    localparam opcode_t op_auipc    = 7'b0010111;
    localparam opcode_t op_jal      = 7'b1101111;
    localparam opcode_t op_jalr     = 7'b1100111;
    localparam opcode_t op_branch   = 7'b1100011;
    localparam opcode_t op_load     = 7'b0000011;
    localparam opcode_t op_store    = 7'b0100011;
    localparam opcode_t op_imm      = 7'b0010011; // addi, slti, shifts by immediate...
    localparam opcode_t op_reg      = 7'b0110011; // register/register
    localparam opcode_t op_misc_mem = 7'b0001111; // fence, treated as nop
    localparam opcode_t op_system   = 7'b1110011; // ecall/ebreak, treated as nop

    // funct3 for op_reg / op_imm
    localparam logic [2:0] f3_add  = 3'b000;      // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;      // srl or sra, funct7 bit 5 picks
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 for op_branch, 010 and 011 are reserved
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // ----------------------------------------
    // alu operations, same encoding as the older core
    // ----------------------------------------
    typedef enum logic [4:0] {
        alu_and    = 5'd0,
        alu_or     = 5'd1,
        alu_xor    = 5'd2,
        alu_add    = 5'd3,
        alu_sub    = 5'd4,
        alu_sll    = 5'd5,
        alu_srl    = 5'd6,
        alu_slt    = 5'd7,                        // signed
        alu_sltu   = 5'd8,
        alu_sra    = 5'd9,
        alu_beq    = 5'd10,                       // 10..15 only drive the cond flag
        alu_bne    = 5'd11,
        alu_blt    = 5'd12,
        alu_bltu   = 5'd13,
        alu_bge    = 5'd14,
        alu_bgeu   = 5'd15,
        alu_pass_b = 5'd16                        // lui
    } alu_op_e;

    typedef enum logic [1:0] {src_a_rs1 = 2'd0, src_a_pc = 2'd1, src_a_zero = 2'd2} src_a_e;
    typedef enum logic {src_b_rs2 = 1'b0, src_b_imm = 1'b1} src_b_e;
    typedef enum logic {res_alu = 1'b0, res_pc4 = 1'b1} result_e;

    // ----------------------------------------
    // stage bundles
    // ----------------------------------------
    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;        // already sign extended by decode
        reg_addr_t rd;
        opcode_t   opcode;
        logic [2:0] funct3;
        logic      funct7_b5;  // inst[30]
    } id_ex_t;

    typedef struct packed {
        alu_op_e alu_op;
        src_a_e  src_a;
        src_b_e  src_b;
        result_e result_sel;
        logic    branch;       // conditional, taken when alu cond is set
        logic    jump;         // jal or jalr, always taken
        logic    jalr;         // target from rs1 instead of pc
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
    } ex_ctrl_t;

    typedef struct packed {
        word_t     result;     // alu result or pc+4, also the memory address
        word_t     store_data;
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
    } ex_mem_t;

endpackage

// File: src/alu_decoder.sv
`timescale 1ns/1ns

module alu_decoder (
    input  riscv_pkg::opcode_t  i_opcode,
    input  logic [2:0]          i_funct3,
    input  logic                i_funct7_b5,
    output riscv_pkg::ex_ctrl_t o_ctrl
);
    import riscv_pkg::*;

    // funct3 to alu op for op_reg and op_imm
    // sub only exists for register forms, sra for both
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic b5,
                                         input logic is_reg);
        alu_op_e op;
        case (f3)
            f3_add:  op = (is_reg && b5) ? alu_sub : alu_add;
            f3_sll:  op = alu_sll;
            f3_slt:  op = alu_slt;
            f3_sltu: op = alu_sltu;
            f3_xor:  op = alu_xor;
            f3_sr:   op = b5 ? alu_sra : alu_srl;
            f3_or:   op = alu_or;
            default: op = alu_and;                // f3_and
        endcase
        return op;
    endfunction

    always_comb begin
        o_ctrl = '0;                              // and, rs1/rs2, alu result, no enables
        case (i_opcode)
            op_reg: begin
                o_ctrl.alu_op    = arith_op(i_funct3, i_funct7_b5, 1'b1);
                o_ctrl.reg_write = 1'b1;
            end
            op_imm: begin
                o_ctrl.alu_op    = arith_op(i_funct3, i_funct7_b5, 1'b0);
                o_ctrl.src_b     = src_b_imm;
                o_ctrl.reg_write = 1'b1;
            end
            op_load: begin                        // address = rs1 + imm
                o_ctrl.alu_op    = alu_add;
                o_ctrl.src_b     = src_b_imm;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.mem_read  = 1'b1;
            end
            op_store: begin
                o_ctrl.alu_op    = alu_add;
                o_ctrl.src_b     = src_b_imm;
                o_ctrl.mem_write = 1'b1;          // rs2 rides along as store data
            end
            op_branch: begin
                o_ctrl.branch = 1'b1;
                case (i_funct3)
                    f3_beq:  o_ctrl.alu_op = alu_beq;
                    f3_bne:  o_ctrl.alu_op = alu_bne;
                    f3_blt:  o_ctrl.alu_op = alu_blt;
                    f3_bge:  o_ctrl.alu_op = alu_bge;
                    f3_bltu: o_ctrl.alu_op = alu_bltu;
                    f3_bgeu: o_ctrl.alu_op = alu_bgeu;
                    default: o_ctrl.branch = 1'b0; // reserved funct3, never taken
                endcase
            end
            op_jal: begin
                o_ctrl.jump       = 1'b1;
                o_ctrl.result_sel = res_pc4;      // link value
                o_ctrl.reg_write  = 1'b1;
            end
            op_jalr: begin
                o_ctrl.jump       = 1'b1;
                o_ctrl.jalr       = 1'b1;
                o_ctrl.result_sel = res_pc4;
                o_ctrl.reg_write  = 1'b1;
            end
            op_lui: begin
                o_ctrl.alu_op    = alu_pass_b;
                o_ctrl.src_a     = src_a_zero;
                o_ctrl.src_b     = src_b_imm;     // upper immediate, low 12 bits zero
                o_ctrl.reg_write = 1'b1;
            end
            op_auipc: begin
                o_ctrl.alu_op    = alu_add;
                o_ctrl.src_a     = src_a_pc;
                o_ctrl.src_b     = src_b_imm;
                o_ctrl.reg_write = 1'b1;
            end
            op_misc_mem, op_system: o_ctrl = '0;  // fence / ecall / ebreak write nothing
            default: o_ctrl = '0;                 // illegal opcode
        endcase
    end

    // a memory op is either a load or a store, the memory stage relies on it
    always_comb begin
        assert (!(o_ctrl.mem_read && o_ctrl.mem_write))
            else $error("alu_decoder: mem_read and mem_write both set, opcode %b", i_opcode);
    end

endmodule

// File: src/operand_select.sv
`timescale 1ns/1ns

module operand_select (
    input  riscv_pkg::id_ex_t   i_id_ex,
    input  riscv_pkg::ex_ctrl_t i_ctrl,
    output riscv_pkg::word_t    o_src_a,
    output riscv_pkg::word_t    o_src_b,
    output riscv_pkg::word_t    o_target,
    output riscv_pkg::word_t    o_pc4
);
    import riscv_pkg::*;

    word_t base;       // pc for branches and jal, rs1 for jalr
    word_t target_sum;

    // ----------------------------------------
    // alu operands
    // ----------------------------------------
    always_comb begin
        case (i_ctrl.src_a)
            src_a_rs1:  o_src_a = i_id_ex.rs1_data;
            src_a_pc:   o_src_a = i_id_ex.pc;     // auipc
            src_a_zero: o_src_a = '0;             // lui
            default:    o_src_a = '0;
        endcase
    end

    always_comb begin
        case (i_ctrl.src_b)
            src_b_imm: o_src_b = i_id_ex.imm;
            default:   o_src_b = i_id_ex.rs2_data;
        endcase
    end

    // ----------------------------------------
    // branch / jump target and link value
    // ----------------------------------------
    assign base       = i_ctrl.jalr ? i_id_ex.rs1_data : i_id_ex.pc;
    assign target_sum = base + i_id_ex.imm;

    always_comb begin
        o_target = target_sum;
        if (i_ctrl.jalr) begin
            o_target[0] = 1'b0;                   // jalr clears the lsb
        end
    end

    assign o_pc4 = i_id_ex.pc + word_t'(4);      // return address for jal/jalr

endmodule

// File: src/alu.sv
`timescale 1ns/1ns

module alu (
    input  riscv_pkg::alu_op_e i_alu_op,
    input  riscv_pkg::word_t   i_src_a,
    input  riscv_pkg::word_t   i_src_b,
    output riscv_pkg::word_t   o_result,
    output logic               o_cond
);
    import riscv_pkg::*;

    logic   is_sub;
    logic   is_cmp;     // branch compare ops, only these may raise o_cond
    word_t  add_b;      // b or ~b
    word_t  add_sum;
    shamt_t shamt;
    logic   eq;
    logic   lt_s;
    logic   lt_u;

    // ----------------------------------------
    // shared add/subtract path
    // ----------------------------------------
    assign is_sub  = (i_alu_op == alu_sub);
    assign add_b   = is_sub ? ~i_src_b : i_src_b; // a - b = a + ~b + 1
    assign add_sum = i_src_a + add_b + word_t'(is_sub);

    assign shamt = i_src_b[$bits(shamt_t)-1:0];   // only low 5 bits of b count

    // comparators, shared by slt/sltu and the branches
    assign eq   = (i_src_a == i_src_b);
    assign lt_s = ($signed(i_src_a) < $signed(i_src_b));
    assign lt_u = (i_src_a < i_src_b);

    assign is_cmp = i_alu_op inside {alu_beq, alu_bne, alu_blt, alu_bltu, alu_bge, alu_bgeu};

    // ----------------------------------------
    // result select
    // ----------------------------------------
    always_comb begin
        o_result = '0;
        o_cond   = 1'b0;
        case (i_alu_op)
            alu_and:  o_result = i_src_a & i_src_b;
            alu_or:   o_result = i_src_a | i_src_b;
            alu_xor:  o_result = i_src_a ^ i_src_b;
            alu_add,
            alu_sub:  o_result = add_sum;
            alu_sll:  o_result = i_src_a << shamt;
            alu_srl:  o_result = i_src_a >> shamt;
            alu_sra:  o_result = $signed(i_src_a) >>> shamt; // sign fill from bit 31
            alu_slt:  o_result = word_t'(lt_s);
            alu_sltu: o_result = word_t'(lt_u);

            // branch compares, result stays zero
            alu_beq:  o_cond = eq;
            alu_bne:  o_cond = ~eq;
            alu_blt:  o_cond = lt_s;
            alu_bltu: o_cond = lt_u;
            alu_bge:  o_cond = ~lt_s;
            alu_bgeu: o_cond = ~lt_u;

            alu_pass_b: o_result = i_src_b;       // lui, imm comes in on b
            default: begin
                o_result = '0;                    // unused codes drive zero
                o_cond   = 1'b0;
            end
        endcase
    end

    // branch_unit takes a branch on cond alone, so it must never leak from other ops
    always_comb begin
        if (!is_cmp) begin
            assert (!o_cond)
                else $error("alu: o_cond high for non-compare op %0d", i_alu_op);
        end
    end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  logic                i_flush,
    input  riscv_pkg::id_ex_t   i_id_ex,
    input  riscv_pkg::ex_ctrl_t i_ctrl,
    input  riscv_pkg::word_t    i_alu_result,
    input  logic                i_cond,
    input  riscv_pkg::word_t    i_target,
    input  riscv_pkg::word_t    i_pc4,
    output logic                o_valid,
    output riscv_pkg::ex_mem_t  o_ex_mem,
    output logic                o_redirect,
    output riscv_pkg::word_t    o_redirect_pc
);
    import riscv_pkg::*;

    logic    live;      // bundle is real and not killed this cycle
    logic    taken;
    ex_mem_t ex_mem_d;

    assign live  = i_valid & ~i_flush;
    assign taken = i_ctrl.jump | (i_ctrl.branch & i_cond);

    // ----------------------------------------
    // next ex/mem bundle
    // ----------------------------------------
    always_comb begin
        ex_mem_d.result     = (i_ctrl.result_sel == res_pc4) ? i_pc4 : i_alu_result;
        ex_mem_d.store_data = i_id_ex.rs2_data;
        ex_mem_d.rd         = i_id_ex.rd;
        // writes to x0 are dropped here so later stages never see them
        ex_mem_d.reg_write  = live & i_ctrl.reg_write & (i_id_ex.rd != '0);
        ex_mem_d.mem_read   = live & i_ctrl.mem_read;
        ex_mem_d.mem_write  = live & i_ctrl.mem_write;
    end

    // ----------------------------------------
    // ex/mem pipeline register
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        o_ex_mem      <= ex_mem_d;                // payload loads every cycle
        o_redirect_pc <= i_target;
        if (i_rst) begin
            o_valid            <= 1'b0;
            o_redirect         <= 1'b0;
            o_ex_mem.reg_write <= 1'b0;           // enables override the payload load
            o_ex_mem.mem_read  <= 1'b0;
            o_ex_mem.mem_write <= 1'b0;
        end else begin
            o_valid    <= live;
            o_redirect <= live & taken;           // one cycle pulse per taken bundle
        end
    end

    // fetch only redirects for an instruction that actually retires from ex
    a_redirect_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        o_redirect |-> o_valid)
        else $error("branch_unit: o_redirect without o_valid");

endmodule

// File: src/stage_execute.sv
`timescale 1ns/1ns

module stage_execute (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_valid,
    input  logic               i_flush,
    input  riscv_pkg::id_ex_t  i_id_ex,
    output logic               o_valid,
    output riscv_pkg::ex_mem_t o_ex_mem,
    output logic               o_redirect,
    output riscv_pkg::word_t   o_redirect_pc
);
    import riscv_pkg::*;

    ex_ctrl_t ctrl;        // decoded control for this bundle
    word_t    src_a;
    word_t    src_b;
    word_t    target;      // branch / jump destination
    word_t    pc4;
    word_t    alu_result;
    logic     cond;        // compare outcome for branches

    // ----------------------------------------
    // control
    // ----------------------------------------
    alu_decoder alu_decoder_i (
        .i_opcode    (i_id_ex.opcode),
        .i_funct3    (i_id_ex.funct3),
        .i_funct7_b5 (i_id_ex.funct7_b5),
        .o_ctrl      (ctrl)
    );

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    operand_select operand_select_i (
        .i_id_ex  (i_id_ex),
        .i_ctrl   (ctrl),
        .o_src_a  (src_a),
        .o_src_b  (src_b),
        .o_target (target),
        .o_pc4    (pc4)
    );

    alu alu_i (
        .i_alu_op (ctrl.alu_op),
        .i_src_a  (src_a),
        .i_src_b  (src_b),
        .o_result (alu_result),
        .o_cond   (cond)
    );

    branch_unit branch_unit_i (     // only stateful block in the stage
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_valid       (i_valid),
        .i_flush       (i_flush),
        .i_id_ex       (i_id_ex),
        .i_ctrl        (ctrl),
        .i_alu_result  (alu_result),
        .i_cond        (cond),
        .i_target      (target),
        .i_pc4         (pc4),
        .o_valid       (o_valid),
        .o_ex_mem      (o_ex_mem),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

endmodule

// File: test/ex_checker.sv
`timescale 1ns/1ns

module ex_checker (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_valid,
    input  logic               i_flush,
    input  riscv_pkg::id_ex_t  i_id_ex,
    input  logic               i_dut_valid,
    input  riscv_pkg::ex_mem_t i_ex_mem,
    input  logic               i_redirect,
    input  riscv_pkg::word_t   i_redirect_pc,
    output int                 o_errors
);
    import riscv_pkg::*;

    // expected response for one issued bundle
    typedef struct packed {
        logic    rst;          // bundle sampled while reset was high
        logic    valid;
        logic    redirect;
        word_t   redirect_pc;
        logic    chk_result;   // result field is defined for this class
        logic    chk_store;
        opcode_t opcode;
        ex_mem_t ex_mem;
    } exp_t;

    exp_t pending[$];          // one entry deep, pushed on posedge, popped on negedge
    int   err_cnt = 0;

    assign o_errors = err_cnt;

    // ----------------------------------------
    // rv32i reference model
    // ----------------------------------------
    function automatic word_t sra32(input word_t v, input logic [4:0] s);
        word_t fill;
        fill = ~(32'hffff_ffff >> s);              // ones where the sign copies land
        return v[31] ? ((v >> s) | fill) : (v >> s);
    endfunction

    function automatic exp_t model(input id_ex_t b, input logic live);
        exp_t  e;
        word_t a;
        word_t bv;
        logic  is_reg;
        logic  taken;
        logic  wr;
        e      = '0;
        taken  = 1'b0;
        wr     = 1'b0;
        is_reg = (b.opcode == op_reg);
        a      = b.rs1_data;
        bv     = is_reg ? b.rs2_data : b.imm;    // second operand for alu classes
        e.opcode            = b.opcode;
        e.ex_mem.rd         = b.rd;
        e.ex_mem.store_data = b.rs2_data;
        e.redirect_pc       = b.pc + b.imm;      // branches and jal
        case (b.opcode)
            op_reg, op_imm: begin
                wr           = 1'b1;
                e.chk_result = 1'b1;
                case (b.funct3)
                    3'b000: e.ex_mem.result = (is_reg && b.funct7_b5) ? a - bv : a + bv;
                    3'b001: e.ex_mem.result = a << bv[4:0];
                    3'b010: e.ex_mem.result = ($signed(a) < $signed(bv)) ? 32'd1 : 32'd0;
                    3'b011: e.ex_mem.result = (a < bv) ? 32'd1 : 32'd0;
                    3'b100: e.ex_mem.result = a ^ bv;
                    3'b101: e.ex_mem.result = b.funct7_b5 ? sra32(a, bv[4:0]) : a >> bv[4:0];
                    3'b110: e.ex_mem.result = a | bv;
                    default: e.ex_mem.result = a & bv;
                endcase
            end
            op_load, op_store: begin             // effective address
                e.ex_mem.result    = a + b.imm;
                e.chk_result       = 1'b1;
                e.chk_store        = (b.opcode == op_store);
                wr                 = (b.opcode == op_load);
                e.ex_mem.mem_read  = live && (b.opcode == op_load);
                e.ex_mem.mem_write = live && (b.opcode == op_store);
            end
            op_branch: begin
                case (b.funct3)
                    3'b000: taken = (a == b.rs2_data);
                    3'b001: taken = (a != b.rs2_data);
                    3'b100: taken = ($signed(a) < $signed(b.rs2_data));
                    3'b101: taken = ($signed(a) >= $signed(b.rs2_data));
                    3'b110: taken = (a < b.rs2_data);
                    3'b111: taken = (a >= b.rs2_data);
                    default: taken = 1'b0;        // reserved encodings
                endcase
            end
            op_jal, op_jalr: begin
                taken           = 1'b1;
                wr              = 1'b1;
                e.chk_result    = 1'b1;
                e.ex_mem.result = b.pc + 32'd4;   // link address
                if (b.opcode == op_jalr) begin
                    e.redirect_pc = (a + b.imm) & 32'hffff_fffe;
                end
            end
            op_lui: begin
                wr              = 1'b1;
                e.chk_result    = 1'b1;
                e.ex_mem.result = b.imm;
            end
            op_auipc: begin
                wr              = 1'b1;
                e.chk_result    = 1'b1;
                e.ex_mem.result = b.pc + b.imm;
            end
            default: e.chk_result = 1'b0;         // fence, system, illegal write nothing
        endcase
        e.valid            = live;
        e.redirect         = live && taken;
        e.ex_mem.reg_write = live && wr && (b.rd != 5'd0);
        return e;
    endfunction

    function automatic string class_name(input opcode_t op);
        case (op)
            op_reg:    return "op_reg";
            op_imm:    return "op_imm";
            op_load:   return "load";
            op_store:  return "store";
            op_branch: return "branch";
            op_jal:    return "jal";
            op_jalr:   return "jalr";
            op_lui:    return "lui";
            op_auipc:  return "auipc";
            default:   return "nop or illegal";
        endcase
    endfunction

    // ----------------------------------------
    // compare
    // ----------------------------------------
    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("** Error %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("** Error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    // inputs are stable at the rising edge, the tb changes them a little later
    always @(posedge i_clk) begin
        exp_t e;
        e     = model(i_id_ex, i_valid && !i_flush && !i_rst);
        e.rst = i_rst;
        pending.push_back(e);
    end

    // registered outputs are settled by the falling edge
    always @(negedge i_clk) begin
        exp_t  e;
        string tn;
        if (pending.size() != 0) begin
            e  = pending.pop_front();
            tn = e.rst ? "reset" : (e.valid ? class_name(e.opcode) : "killed bundle");
            check_bit({tn, " o_valid"}, e.valid, i_dut_valid);
            check_bit({tn, " o_redirect"}, e.redirect, i_redirect);
            check_bit({tn, " reg_write"}, e.ex_mem.reg_write, i_ex_mem.reg_write);
            check_bit({tn, " mem_read"}, e.ex_mem.mem_read, i_ex_mem.mem_read);
            check_bit({tn, " mem_write"}, e.ex_mem.mem_write, i_ex_mem.mem_write);
            if (e.redirect) begin
                check_word({tn, " redirect_pc"}, e.redirect_pc, i_redirect_pc);
            end
            if (e.valid && e.chk_result) begin
                check_word({tn, " result"}, e.ex_mem.result, i_ex_mem.result);
            end
            if (e.valid && e.chk_store) begin
                check_word({tn, " store_data"}, e.ex_mem.store_data, i_ex_mem.store_data);
            end
            if (e.ex_mem.reg_write) begin
                check_word({tn, " rd"}, {27'd0, e.ex_mem.rd}, {27'd0, i_ex_mem.rd});
            end
        end
    end

endmodule

// File: test/tb_stage_execute.sv
`timescale 1ns/1ns

module tb_stage_execute;
    import riscv_pkg::*;

    localparam int n_instr     = 2000;
    localparam int rst_timeout = 20;    // cycles

    logic    clk;
    logic    rst;
    logic    valid;
    logic    flush;
    id_ex_t  id_ex;
    logic    dut_valid;
    ex_mem_t ex_mem;
    logic    redirect;
    word_t   redirect_pc;
    int      errors;
    int      wait_cnt;
    logic [31:0] r;

    stage_execute stage_execute_i (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_valid       (valid),
        .i_flush       (flush),
        .i_id_ex       (id_ex),
        .o_valid       (dut_valid),
        .o_ex_mem      (ex_mem),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    ex_checker ex_checker_i (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_valid       (valid),
        .i_flush       (flush),
        .i_id_ex       (id_ex),
        .i_dut_valid   (dut_valid),
        .i_ex_mem      (ex_mem),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_errors      (errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;          // 40 ns period
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    // operands lean toward sign boundaries and zero
    function automatic word_t rand_operand();
        logic [31:0] s;
        s = $urandom();
        case (s[2:0])
            3'd0:    return 32'h8000_0000;
            3'd1:    return 32'h7fff_ffff;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return 32'h0000_0000;
            default: return $urandom();
        endcase
    endfunction

    function automatic id_ex_t make_bundle();
        id_ex_t      b;
        logic [31:0] k;
        logic [31:0] s;
        k = $urandom();
        s = $urandom();
        b.pc        = $urandom() & 32'hffff_fffc;
        b.rs1_data  = rand_operand();
        b.rs2_data  = (k[4:3] == 2'b00) ? b.rs1_data : rand_operand(); // equal operands
        b.rd        = k[12:8];
        b.funct3    = k[15:13];
        b.funct7_b5 = 1'b0;
        b.imm       = {{20{s[11]}}, s[11:0]};  // i-type unless replaced below
        case (k[19:16])
            4'd0, 4'd1: begin
                b.opcode    = op_reg;
                b.funct7_b5 = k[20] && (b.funct3 == 3'b000 || b.funct3 == 3'b101);
            end
            4'd2, 4'd3: begin
                b.opcode = op_imm;
                if (b.funct3 == 3'b001) begin
                    b.imm = {27'd0, s[4:0]};             // slli
                end else if (b.funct3 == 3'b101) begin
                    b.imm = {21'd0, k[20], 5'd0, s[4:0]}; // srli or srai
                end
                b.funct7_b5 = b.imm[10];                 // inst[30]
            end
            4'd4: begin
                b.opcode = op_load;
                b.funct3 = (k[14:13] == 2'b11) ? 3'b100 : {1'b0, k[14:13]};
            end
            4'd5: begin
                b.opcode = op_store;
                b.funct3 = (k[14:13] == 2'b11) ? 3'b010 : {1'b0, k[14:13]};
            end
            4'd6, 4'd7: begin
                b.opcode = op_branch;
                if (b.funct3[2:1] == 2'b01) begin
                    b.funct3[2:1] = 2'b11;               // skip reserved codes
                end
                b.imm = {{19{s[12]}}, s[12:1], 1'b0};
            end
            4'd8: begin
                b.opcode = op_jal;
                b.imm    = {{11{s[20]}}, s[20:1], 1'b0};
            end
            4'd9:    b.opcode = op_jalr;
            4'd10:   b.opcode = op_lui;
            4'd11:   b.opcode = op_auipc;
            4'd12:   b.opcode = op_misc_mem;
            4'd13:   b.opcode = op_system;
            default: b.opcode = k[26:20];                // mostly illegal
        endcase
        if (b.opcode == op_lui || b.opcode == op_auipc) begin
            b.imm = {s[31:12], 12'd0};
        end
        if (b.opcode == op_jal || b.opcode == op_jalr || b.opcode == op_misc_mem
            || b.opcode == op_system) begin
            b.funct3 = 3'b000;
        end
        return b;
    endfunction

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h1437e326));
        rst          = 1'b1;
        valid        = 1'b1;             // live jal to x1 while reset is held
        flush        = 1'b0;
        id_ex        = '0;
        id_ex.opcode = op_jal;
        id_ex.rd     = 5'd1;
        wait_cnt     = 0;
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
        valid = 1'b0;

        // outputs must be idle once reset is released
        while ((dut_valid !== 1'b0 || redirect !== 1'b0) && wait_cnt < rst_timeout) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (wait_cnt >= rst_timeout) begin
            $display("timeout, o_valid or o_redirect did not go low after reset");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            for (int n = 0; n < n_instr; n++) begin
                id_ex = make_bundle();
                r     = $urandom();
                valid = (r[6:0] < 7'd115);       // about 90 percent
                flush = (r[14:8] < 7'd6);        // about 5 percent
                @(posedge clk);
                #2;
            end
            valid = 1'b0;
            flush = 1'b0;
            repeat (2) @(posedge clk);           // let the last bundle be compared
            #2;
            $display("checks done, error count %0d", errors);
            if (errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

// File: src.f
src/riscv_pkg.sv
src/alu_decoder.sv
src/operand_select.sv
src/alu.sv
src/branch_unit.sv
src/stage_execute.sv
test/ex_checker.sv
test/tb_stage_execute.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_stage_execute
./obj_dir/Vtb_stage_execute > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
